/* Makefile */
.PHONY: all run clean

all: run

obj_dir/Vrotate_tb: list.f $(wildcard src/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing -j 0 --top-module rotate_tb -f list.f

sim.log: obj_dir/Vrotate_tb
	./obj_dir/Vrotate_tb > sim.log 2>&1 || true

run: obj_dir/Vrotate_tb
	./obj_dir/Vrotate_tb 2>&1 | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/rotate_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rotate_tb import rotate_pkg::*; ();

	logic        clk = 1'b0;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [2:0]  wb_adr;
	logic [15:0] wb_dat_w;
	logic [15:0] wb_dat_r;
	logic        wb_ack;
	logic        opto_sw;
	logic        motor_pwm;
	logic        locked;
	logic [5:0]  fall_cnt;
	logic        zero_sign;
	logic        opto_fall;

	logic [31:0] lfsr = 32'hcd58bbad;
	int          cyc_now = 0;
	int          last_fall = 0;
	int          falls_driven = 0;
	int          total_per = 0;
	int          fall_q[$];	// tooth periods still to be seen by the DUT
	int          errors = 0;

	// reference model state
	int          m_prev = 0;
	int          m_cnt = 0;
	int          m_duty = 0;
	int          m_run = 0;
	int          m_init = 0;
	logic        m_prev_ok = 1'b0;
	logic        m_started = 1'b0;
	logic        m_valid = 1'b0;
	logic        m_zero_seen = 1'b0;
	logic        m_locked = 1'b0;
	logic [1:0]  m_mode = 2'd0;
	logic [1:0]  m_speed = 2'd0;

	// pwm period mirror
	logic [9:0]  pwm_phase;
	int          high_cnt = 0;
	int          period_duty = 0;
	int          duty_last = 0;

	rotate_control i_rotate_control (
		.i_clk_50m      (clk),
		.i_rst_n        (rst_n),
		.i_wb_cyc       (wb_cyc),
		.i_wb_stb       (wb_stb),
		.i_wb_we        (wb_we),
		.i_wb_adr       (wb_adr),
		.i_wb_dat       (wb_dat_w),
		.o_wb_dat       (wb_dat_r),
		.o_wb_ack       (wb_ack),
		.i_opto_switch  (opto_sw),
		.o_motor_pwm    (motor_pwm),
		.o_motor_locked (locked),
		.o_fall_cnt     (fall_cnt),
		.o_zero_sign    (zero_sign),
		.o_opto_fall    (opto_fall)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cyc_now <= cyc_now + 1;
		if (cyc_now > 2 * total_per + 40000) begin
			fail_run("simulation timed out waiting for the DUT");
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped");
	endtask

	task automatic check_val(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "check failed");
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic wb_access(input logic we, input logic [2:0] adr, input logic [15:0] wdat,
		output logic [15:0] rdat);
		int waited;
		@(posedge clk);
		#2;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		waited   = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (!wb_ack && waited < 16);
		if (!wb_ack) begin
			fail_run("no Wishbone ack within 16 cycles");
		end else begin
			check_val("o_wb_ack delay in cycles", waited, 1);	// ack on the next edge
			rdat = wb_dat_r;
			#1;
			wb_cyc = 1'b0;	// drop request 2 ns after the ack edge
			wb_stb = 1'b0;
			wb_we  = 1'b0;
		end
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [15:0] rdat);
		wb_access(1'b0, adr, 16'h0000, rdat);
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [15:0] dat);
		logic [15:0] unused;
		wb_access(1'b1, adr, dat, unused);
		if (adr == 3'd0) begin
			if (dat[1:0] != m_mode) begin
				m_valid = 1'b0;	// next fall only restarts the period
			end
			m_mode  = dat[1:0];
			m_speed = dat[5:4];
		end else if (adr == 3'd1) begin
			m_init = int'(dat[9:0]);
		end
		@(posedge clk);
		#2;
		if (m_mode == CAL) begin
			m_duty   = m_init;
			m_run    = 0;
			m_locked = 1'b0;
		end else if (m_mode != REGULATE) begin
			m_duty   = 0;	// off, and the unused mode code
			m_run    = 0;
			m_locked = 1'b0;
		end
	endtask

	task automatic update_duty(input int per);
		int tgt;
		tgt = int'(TARGET_PERIOD[m_speed]);
		if (per > tgt + SPEED_TOL) begin
			m_duty   = (m_duty + PWM_STEP > 1023) ? 1023 : m_duty + PWM_STEP;
			m_run    = 0;
			m_locked = 1'b0;
		end else if (per < tgt - SPEED_TOL) begin
			m_duty   = (m_duty < PWM_STEP) ? 0 : m_duty - PWM_STEP;
			m_run    = 0;
			m_locked = 1'b0;
		end else begin
			if (m_run < LOCK_COUNT) begin
				m_run++;
			end
			if (m_run >= LOCK_COUNT) begin
				m_locked = 1'b1;
			end
		end
	endtask

	task automatic check_fall();
		int          per;
		logic        gap;
		logic        meas;
		logic [15:0] rd;
		if (fall_q.size() == 0) begin
			fail_run("opto_fall pulse without a driven tooth fall");
		end else begin
			per  = fall_q.pop_front();
			gap  = m_prev_ok && (per > m_prev + m_prev / 2);
			meas = m_valid && !gap;
			if (m_started && !gap) begin
				m_prev    = per;
				m_prev_ok = 1'b1;
			end
			if (gap) begin
				m_cnt       = 0;	// fall after the missing tooth
				m_zero_seen = 1'b1;
			end else if (m_cnt != FALLS_PER_REV - 1) begin
				m_cnt++;
			end
			m_started = 1'b1;
			m_valid   = 1'b1;
			check_val("o_fall_cnt", int'(fall_cnt), m_cnt);
			check_val("o_zero_sign", int'(zero_sign), int'(gap));
			@(posedge clk);
			#1;
			if (m_mode == REGULATE && meas) begin
				update_duty(per);
			end
			check_val("o_motor_locked", int'(locked), int'(m_locked));
			wb_read(3'd3, rd);
			check_val("PWM_NOW", int'(rd), m_duty);
			wb_read(3'd2, rd);
			check_val("STATUS locked", int'(rd[15]), int'(m_locked));
			check_val("STATUS zero_seen", int'(rd[14]), int'(m_zero_seen));
			check_val("STATUS fall_cnt", int'(rd[5:0]), m_cnt);
		end
	endtask

	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (rst_n && opto_fall) begin
				check_fall();
			end else if (rst_n) begin
				check_val("o_zero_sign", int'(zero_sign), 0);
			end
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			pwm_phase <= '0;
		end else begin
			pwm_phase <= pwm_phase + 10'd1;
		end
	end

	// high cycles per pwm period against the duty latched at its start
	always @(posedge clk) begin
		#3;
		if (rst_n) begin
			if (pwm_phase == 10'd0) begin
				check_val("o_motor_pwm high cycles", high_cnt, period_duty);
				period_duty = duty_last;
				high_cnt    = 0;
			end
			high_cnt  = high_cnt + int'(motor_pwm);
			duty_last = m_duty;
		end
	end

	task automatic drive_tooth(input int period);
		int high;
		int g_at;
		int g_len;
		high    = period / 2;
		opto_sw = 1'b1;
		if (rand_bits(3) == 0) begin
			g_at  = 12 + rand_bits(4);
			g_len = 1 + rand_bits(2) % 3;
			wait_cycles(g_at);
			opto_sw = 1'b0;	// short dropout, must be filtered
			wait_cycles(g_len);
			opto_sw = 1'b1;
			wait_cycles(high - g_at - g_len);
		end else begin
			wait_cycles(high);
		end
		opto_sw = 1'b0;
		fall_q.push_back((falls_driven > 0) ? cyc_now - last_fall : 0);
		last_fall = cyc_now;
		falls_driven++;
		total_per += period;
		wait_cycles(period - high);
	endtask

	task automatic drive_rev(input int base, input int spread);
		int per;
		for (int t = 0; t < FALLS_PER_REV; t++) begin
			per = base - spread + rand_bits(8) % (2 * spread + 1);
			if (t == 0) begin
				per = per * 2;	// missing slot
			end
			drive_tooth(per);
		end
	endtask

	task automatic reg_test();
		logic [15:0] v;
		logic [15:0] rd;
		for (int n = 0; n < 8; n++) begin
			v = 16'(rand_bits(16));
			wb_write(3'd0, v);
			wb_read(3'd0, rd);
			check_val("CFG", int'(rd), int'(v & 16'h0033));
			v = 16'(rand_bits(16));
			wb_write(3'd1, v);
			wb_read(3'd1, rd);
			check_val("PWM_INIT", int'(rd), int'(v & 16'h03ff));
			v = 16'(rand_bits(16));
			wb_write(3'(4 + n % 4), v);
			wb_read(3'(4 + n % 4), rd);
			check_val("unmapped read", int'(rd), 0);
		end
		wb_write(3'd0, 16'h0000);
	endtask

	initial begin
		int tgt;
		int spd;
		rst_n    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 3'd0;
		wb_dat_w = 16'h0000;
		opto_sw  = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		reg_test();
		drive_rev(300, 3);	// motor off, angle counting only
		drive_rev(300, 3);
		drive_rev(260, 3);
		wb_write(3'd1, 16'(rand_bits(10)));
		wb_write(3'd0, 16'h0001);
		drive_rev(300, 3);
		for (int r = 0; r < 3; r++) begin
			spd = rand_bits(2);
			tgt = int'(TARGET_PERIOD[spd]);
			wb_write(3'd0, 16'(2 | (spd << 4)));
			drive_rev(tgt + 40, 4);
			drive_rev(tgt, 30);
			drive_rev(tgt, 6);	// stays in band long enough to lock
			drive_rev(tgt - 40, 4);
		end
		wb_write(3'd0, 16'h0000);
		drive_rev(300, 3);
		wait_cycles(2100);	// two full pwm periods with zero duty
		check_val("pending tooth falls", fall_q.size(), 0);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
src/rotate_pkg.sv
src/rotate_regs.sv
src/opto_filter.sv
src/motor_speed_ctrl.sv
src/angle_encoder.sv
src/rotate_control.sv
bench/rotate_tb.sv

/* src/angle_encoder.sv */
`timescale 1ns/100ps
`default_nettype none

module angle_encoder import rotate_pkg::*; (
	input  wire logic           i_clk_50m,
	input  wire logic           i_rst_n,
	input  wire logic           i_opto_fall,
	output logic                o_gap,
	output logic [CNT_BITS-1:0] o_fall_cnt,
	output logic                o_zero_sign,
	output logic                o_zero_seen,
	output logic                o_opto_fall
);

	angle_state_e           state;
	logic [PERIOD_BITS-1:0] tooth_cnt;
	logic [PERIOD_BITS-1:0] prev_period;	// last accepted non-gap period
	logic [PERIOD_BITS:0]   gap_limit;
	logic                   cnt_run;	// counter started by a fall
	logic                   prev_ok;
	logic                   is_gap;

	assign gap_limit   = {1'b0, prev_period} + {1'b0, prev_period >> GAP_RATIO};
	assign is_gap      = prev_ok && ({1'b0, tooth_cnt} > gap_limit);
	assign o_gap       = i_opto_fall & is_gap;	// same cycle as the fall
	assign o_zero_seen = (state == TRACK);	// tracking from the first zero on

	always_ff @(posedge i_clk_50m) begin
		if (!i_rst_n) begin
			tooth_cnt <= '0;
		end else if (i_opto_fall) begin
			tooth_cnt <= PERIOD_BITS'(1);
		end else if (tooth_cnt != '1) begin
			tooth_cnt <= tooth_cnt + 1'b1;
		end
	end

	// reference period, never taken from a gap
	always_ff @(posedge i_clk_50m) begin
		if (!i_rst_n) begin
			cnt_run     <= 1'b0;
			prev_ok     <= 1'b0;
			prev_period <= '0;
		end else if (i_opto_fall) begin
			cnt_run <= 1'b1;
			if (cnt_run && !is_gap) begin
				prev_period <= tooth_cnt;
				prev_ok     <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (!i_rst_n) begin
			state       <= SEARCH;
			o_fall_cnt  <= '0;
			o_zero_sign <= 1'b0;
			o_opto_fall <= 1'b0;
		end else begin
			o_opto_fall <= i_opto_fall;	// aligned with the new count
			o_zero_sign <= o_gap;
			if (i_opto_fall) begin
				if (is_gap) begin
					o_fall_cnt <= '0;
					state      <= TRACK;
				end else if (o_fall_cnt != CNT_BITS'(FALLS_PER_REV - 1)) begin
					o_fall_cnt <= o_fall_cnt + 1'b1;	// holds on the last tooth until a gap
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/motor_speed_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module motor_speed_ctrl import rotate_pkg::*; (
	input  wire logic           i_clk_50m,
	input  wire logic           i_rst_n,
	input  wire rotate_cfg_t    i_cfg,
	input  wire logic           i_opto_fall,
	input  wire logic           i_gap,
	output logic [PWM_BITS-1:0] o_pwm_value,
	output logic                o_locked,
	output logic                o_motor_pwm
);

	logic [PERIOD_BITS-1:0] tooth_cnt;
	logic                   tooth_valid;	// counter was restarted by a fall
	rotate_mode_e           mode_q;
	logic                   mode_chg;
	logic [PERIOD_BITS-1:0] meas_period;
	logic                   meas_stb;
	logic [PERIOD_BITS-1:0] band_hi;
	logic [PERIOD_BITS-1:0] band_lo;
	logic [LOCK_BITS-1:0]   run_cnt;
	logic [PWM_BITS-1:0]    pwm_cnt;
	logic [PWM_BITS-1:0]    duty_lat;

	assign mode_chg = (i_cfg.mode != mode_q);
	assign band_hi  = TARGET_PERIOD[i_cfg.speed] + PERIOD_BITS'(SPEED_TOL);
	assign band_lo  = TARGET_PERIOD[i_cfg.speed] - PERIOD_BITS'(SPEED_TOL);

	// tooth period, one cycle per count, saturating
	always_ff @(posedge i_clk_50m) begin
		if (!i_rst_n) begin
			tooth_cnt   <= '0;
			tooth_valid <= 1'b0;
			mode_q      <= OFF;
			meas_stb    <= 1'b0;
		end else begin
			mode_q   <= i_cfg.mode;
			meas_stb <= i_opto_fall & tooth_valid & ~i_gap & ~mode_chg;
			if (i_opto_fall) begin
				tooth_cnt <= PERIOD_BITS'(1);
			end else if (tooth_cnt != '1) begin
				tooth_cnt <= tooth_cnt + 1'b1;
			end
			if (i_opto_fall) begin
				tooth_valid <= 1'b1;
			end else if (mode_chg) begin
				tooth_valid <= 1'b0;	// first fall in new mode only restarts
			end
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (i_opto_fall) begin
			meas_period <= tooth_cnt;
		end
	end

	// duty and lock, one cycle after the fall
	always_ff @(posedge i_clk_50m) begin
		if (!i_rst_n) begin
			o_pwm_value <= '0;
			o_locked    <= 1'b0;
			run_cnt     <= '0;
		end else begin
			case (i_cfg.mode)
				REGULATE: begin
					if (meas_stb) begin
						if (meas_period > band_hi) begin	// too slow
							o_pwm_value <= (o_pwm_value > PWM_BITS'(2**PWM_BITS - 1 - PWM_STEP)) ?
								'1 : o_pwm_value + PWM_BITS'(PWM_STEP);
							run_cnt  <= '0;
							o_locked <= 1'b0;
						end else if (meas_period < band_lo) begin	// too fast
							o_pwm_value <= (o_pwm_value < PWM_BITS'(PWM_STEP)) ?
								'0 : o_pwm_value - PWM_BITS'(PWM_STEP);
							run_cnt  <= '0;
							o_locked <= 1'b0;
						end else begin
							if (run_cnt < LOCK_BITS'(LOCK_COUNT)) begin
								run_cnt <= run_cnt + 1'b1;
							end
							if (run_cnt >= LOCK_BITS'(LOCK_COUNT - 1)) begin
								o_locked <= 1'b1;
							end
						end
					end
				end
				CAL: begin
					o_pwm_value <= i_cfg.pwm_init;
					run_cnt     <= '0;
					o_locked    <= 1'b0;
				end
				default: begin
					o_pwm_value <= '0;	// motor off
					run_cnt     <= '0;
					o_locked    <= 1'b0;
				end
			endcase
		end
	end

	// new duty takes effect as the counter wraps to zero
	always_ff @(posedge i_clk_50m) begin
		if (!i_rst_n) begin
			pwm_cnt  <= '0;
			duty_lat <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			if (pwm_cnt == '1) begin
				duty_lat <= o_pwm_value;
			end
		end
	end

	assign o_motor_pwm = (pwm_cnt < duty_lat);

endmodule

`default_nettype wire

/* src/opto_filter.sv */
`timescale 1ns/100ps
`default_nettype none

module opto_filter import rotate_pkg::*; (
	input  wire logic i_clk_50m,
	input  wire logic i_rst_n,
	input  wire logic i_opto_switch,
	output logic      o_opto_level,
	output logic      o_opto_fall
);

	logic [1:0]           sync_q;	// [1] is the synchronized level
	logic [FILT_BITS-1:0] stab_cnt;
	logic                 level_due;

	// input has differed for FILT_LEN cycles including this one
	assign level_due = (sync_q[1] != o_opto_level) &&
		(stab_cnt == FILT_BITS'(FILT_LEN - 1));

	always_ff @(posedge i_clk_50m) begin
		if (!i_rst_n) begin
			sync_q       <= '0;
			stab_cnt     <= '0;
			o_opto_level <= 1'b0;
			o_opto_fall  <= 1'b0;
		end else begin
			sync_q      <= {sync_q[0], i_opto_switch};
			o_opto_fall <= level_due & o_opto_level;	// high to low only
			if (sync_q[1] == o_opto_level) begin
				stab_cnt <= '0;	// glitch gone, start over
			end else if (level_due) begin
				o_opto_level <= sync_q[1];
				stab_cnt     <= '0;
			end else begin
				stab_cnt <= stab_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/rotate_control.sv */
`timescale 1ns/100ps
`default_nettype none

module rotate_control import rotate_pkg::*; (
	input  wire logic           i_clk_50m,
	input  wire logic           i_rst_n,
	input  wire logic           i_wb_cyc,
	input  wire logic           i_wb_stb,
	input  wire logic           i_wb_we,
	input  wire logic [2:0]     i_wb_adr,
	input  wire logic [15:0]    i_wb_dat,
	output logic      [15:0]    o_wb_dat,
	output logic                o_wb_ack,
	input  wire logic           i_opto_switch,	// code disk optical switch
	output logic                o_motor_pwm,
	output logic                o_motor_locked,
	output logic [CNT_BITS-1:0] o_fall_cnt,
	output logic                o_zero_sign,
	output logic                o_opto_fall
);

	rotate_cfg_t         cfg;
	wire rotate_status_t status;	// fields come from two blocks
	logic                opto_fall;
	logic                gap;

	assign o_motor_locked = status.locked;
	assign o_fall_cnt     = status.fall_cnt;

	rotate_regs u_regs (
		.i_clk_50m (i_clk_50m),
		.i_rst_n   (i_rst_n),
		.i_wb_cyc  (i_wb_cyc),
		.i_wb_stb  (i_wb_stb),
		.i_wb_we   (i_wb_we),
		.i_wb_adr  (i_wb_adr),
		.i_wb_dat  (i_wb_dat),
		.o_wb_dat  (o_wb_dat),
		.o_wb_ack  (o_wb_ack),
		.i_status  (status),
		.o_cfg     (cfg)
	);

	opto_filter u_filter (
		.i_clk_50m     (i_clk_50m),
		.i_rst_n       (i_rst_n),
		.i_opto_switch (i_opto_switch),
		.o_opto_level  (),	// level only used inside the filter
		.o_opto_fall   (opto_fall)
	);

	motor_speed_ctrl u_motor (
		.i_clk_50m   (i_clk_50m),
		.i_rst_n     (i_rst_n),
		.i_cfg       (cfg),
		.i_opto_fall (opto_fall),
		.i_gap       (gap),
		.o_pwm_value (status.pwm_value),
		.o_locked    (status.locked),
		.o_motor_pwm (o_motor_pwm)
	);

	angle_encoder u_angle (
		.i_clk_50m   (i_clk_50m),
		.i_rst_n     (i_rst_n),
		.i_opto_fall (opto_fall),
		.o_gap       (gap),
		.o_fall_cnt  (status.fall_cnt),
		.o_zero_sign (o_zero_sign),
		.o_zero_seen (status.zero_seen),
		.o_opto_fall (o_opto_fall)
	);

endmodule

`default_nettype wire

/* src/rotate_pkg.sv */
`default_nettype none

package rotate_pkg;

	localparam int FILT_LEN      = 4;	// stable cycles before the filter follows
	localparam int FILT_BITS     = $clog2(FILT_LEN);
	localparam int TEETH_PER_REV = 36;
	localparam int FALLS_PER_REV = TEETH_PER_REV - 1;	// one slot is missing
	localparam int CNT_BITS      = 6;
	localparam int GAP_RATIO     = 1;	// gap if period > prev + (prev >> GAP_RATIO)
	localparam int PERIOD_BITS   = 16;
	localparam int SPEED_TOL     = 8;
	localparam int PWM_STEP      = 4;
	localparam int PWM_BITS      = 10;	// 1024 cycle pwm period
	localparam int LOCK_COUNT    = 8;
	localparam int LOCK_BITS     = $clog2(LOCK_COUNT + 1);

	// tooth period in clocks, indexed by speed code
	localparam logic [PERIOD_BITS-1:0] TARGET_PERIOD [4] = '{
		16'd400, 16'd320, 16'd256, 16'd200
	};

	typedef enum logic [1:0] {
		OFF      = 2'd0,
		CAL      = 2'd1,
		REGULATE = 2'd2
	} rotate_mode_e;

	typedef enum logic [2:0] {
		CFG      = 3'd0,
		PWM_INIT = 3'd1,
		STATUS   = 3'd2,	// read only
		PWM_NOW  = 3'd3 	// read only
	} reg_addr_e;

	typedef enum logic {
		SEARCH = 1'b0,	// no zero reference yet
		TRACK  = 1'b1
	} angle_state_e;

	typedef struct packed {
		rotate_mode_e        mode;
		logic [1:0]          speed;
		logic [PWM_BITS-1:0] pwm_init;
	} rotate_cfg_t;

	typedef struct packed {
		logic [PWM_BITS-1:0] pwm_value;
		logic                locked;
		logic [CNT_BITS-1:0] fall_cnt;
		logic                zero_seen;
	} rotate_status_t;

endpackage

`default_nettype wire

/* src/rotate_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module rotate_regs import rotate_pkg::*; (
	input  wire logic            i_clk_50m,
	input  wire logic            i_rst_n,
	input  wire logic            i_wb_cyc,
	input  wire logic            i_wb_stb,
	input  wire logic            i_wb_we,
	input  wire logic [2:0]      i_wb_adr,
	input  wire logic [15:0]     i_wb_dat,
	output logic      [15:0]     o_wb_dat,
	output logic                 o_wb_ack,
	input  wire rotate_status_t  i_status,
	output rotate_cfg_t          o_cfg
);

	logic        wb_req;
	logic [15:0] rd_word;

	// new request only while no ack is out
	assign wb_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;

	always_ff @(posedge i_clk_50m) begin
		if (!i_rst_n) begin
			o_wb_ack <= 1'b0;
		end else begin
			o_wb_ack <= wb_req;	// single cycle ack
		end
	end

	// writes land on the same edge that raises ack
	always_ff @(posedge i_clk_50m) begin
		if (!i_rst_n) begin
			o_cfg.mode     <= OFF;
			o_cfg.speed    <= '0;
			o_cfg.pwm_init <= '0;
		end else if (wb_req && i_wb_we) begin
			case (reg_addr_e'(i_wb_adr))
				CFG: begin
					o_cfg.mode  <= rotate_mode_e'(i_wb_dat[1:0]);
					o_cfg.speed <= i_wb_dat[5:4];
				end
				PWM_INIT: begin
					o_cfg.pwm_init <= i_wb_dat[PWM_BITS-1:0];
				end
				default: begin
					// read only or unmapped
				end
			endcase
		end
	end

	always_comb begin
		rd_word = '0;
		case (reg_addr_e'(i_wb_adr))
			CFG: begin
				rd_word[1:0] = o_cfg.mode;
				rd_word[5:4] = o_cfg.speed;
			end
			PWM_INIT: begin
				rd_word[PWM_BITS-1:0] = o_cfg.pwm_init;
			end
			STATUS: begin
				rd_word[15]           = i_status.locked;
				rd_word[14]           = i_status.zero_seen;
				rd_word[CNT_BITS-1:0] = i_status.fall_cnt;
			end
			PWM_NOW: begin
				rd_word[PWM_BITS-1:0] = i_status.pwm_value;
			end
			default: begin
				rd_word = '0;	// unmapped reads zero
			end
		endcase
	end

	// status sampled at the request edge, valid with ack
	always_ff @(posedge i_clk_50m) begin
		if (wb_req) begin
			o_wb_dat <= rd_word;
		end
	end

endmodule

`default_nettype wire
